//--- cq_offset_mgr.sv
`timescale 1ns/100ps

module cq_offset_mgr (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  logic [rdma_pkg::CQE_SHIFT_W-1:0] iv_cqe_shift,
  cq_req_if.mgr                            rtc,
  cq_req_if.mgr                            rrc,
  cq_req_if.mgr                            ee,
  output logic                             o_init_finish
);

  localparam int CN = rdma_pkg::CLIENT_NUM;
  localparam int SW = rdma_pkg::CQ_SEL_W;
  localparam int ZW = rdma_pkg::CQ_SIZE_W;
  localparam int OW = rdma_pkg::CQ_OFFSET_W;

  // Producer pointer per queue that the init sweep clears
  logic [OW-1:0]     ptr_table [rdma_pkg::CQ_NUM];
  logic [SW-1:0]     init_cnt;

  logic [CN-1:0]     req_valid;
  logic [SW-1:0]     req_sel  [CN];
  logic [ZW-1:0]     req_size [CN];

  logic [CN-1:0]     pend;
  logic [SW-1:0]     pend_sel  [CN];
  logic [ZW-1:0]     pend_size [CN];

  rdma_pkg::client_e grant;
  logic              serve;
  logic [OW-1:0]     cur_ptr;
  logic [ZW-1:0]     step;
  logic [ZW-1:0]     adv_ptr;
  logic [OW-1:0]     next_ptr;

  logic [CN-1:0]     resp_valid_q;
  logic [OW-1:0]     resp_offset_q;

  assign req_valid = {ee.req_valid, rrc.req_valid, rtc.req_valid};
  assign req_sel[rdma_pkg::RTC]  = rtc.cq_index[SW-1:0];
  assign req_sel[rdma_pkg::RRC]  = rrc.cq_index[SW-1:0];
  assign req_sel[rdma_pkg::EE]   = ee.cq_index[SW-1:0];
  assign req_size[rdma_pkg::RTC] = rtc.cq_size;
  assign req_size[rdma_pkg::RRC] = rrc.cq_size;
  assign req_size[rdma_pkg::EE]  = ee.cq_size;

  // Lowest client number wins
  always_comb begin
    grant = rdma_pkg::RTC;
    for (int c = CN - 1; c >= 0; c--) begin
      if (pend[c]) begin
        grant = rdma_pkg::client_e'(c);
      end
    end
  end

  assign serve    = |pend;
  assign cur_ptr  = ptr_table[pend_sel[grant]];
  assign step     = {{(ZW - 1){1'b0}}, 1'b1} << iv_cqe_shift;
  assign adv_ptr  = {{(ZW - OW){1'b0}}, cur_ptr} + step;
  // Wrap once the next entry would fall past the queue end
  assign next_ptr = (adv_ptr >= pend_size[grant]) ? '0 : adv_ptr[OW-1:0];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      init_cnt      <= '0;
      o_init_finish <= 1'b0;
      pend          <= '0;
      resp_valid_q  <= '0;
    end else begin
      if (!o_init_finish) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == SW'(rdma_pkg::CQ_NUM - 1)) begin
          o_init_finish <= 1'b1;
        end
      end
      resp_valid_q <= '0;
      if (serve) begin
        pend[grant]         <= 1'b0;
        resp_valid_q[grant] <= 1'b1;
      end
      for (int c = 0; c < CN; c++) begin
        if (req_valid[c] && o_init_finish) begin
          pend[c] <= 1'b1;
        end
      end
    end
  end

  // Pointer table, captured request fields and returned offset
  always_ff @(posedge clk) begin
    if (!o_init_finish) begin
      ptr_table[init_cnt] <= '0;
    end else if (serve) begin
      ptr_table[pend_sel[grant]] <= next_ptr;
    end
    if (serve) begin
      resp_offset_q <= cur_ptr;
    end
    for (int c = 0; c < CN; c++) begin
      if (req_valid[c]) begin
        pend_sel[c]  <= req_sel[c];
        pend_size[c] <= req_size[c];
      end
    end
  end

  assign rtc.resp_valid = resp_valid_q[rdma_pkg::RTC];
  assign rrc.resp_valid = resp_valid_q[rdma_pkg::RRC];
  assign ee.resp_valid  = resp_valid_q[rdma_pkg::EE];
  assign rtc.cq_offset  = resp_offset_q;
  assign rrc.cq_offset  = resp_offset_q;
  assign ee.cq_offset   = resp_offset_q;

endmodule

//--- cq_req_if.sv
`timescale 1ns/100ps

interface cq_req_if;

  // One-cycle request pulse with its queue fields
  logic                             req_valid;
  logic [rdma_pkg::CQ_INDEX_W-1:0]  cq_index;
  logic [rdma_pkg::CQ_SIZE_W-1:0]   cq_size;

  // One-cycle response pulse with the entry offset
  logic                             resp_valid;
  logic [rdma_pkg::CQ_OFFSET_W-1:0] cq_offset;

  modport client (
    output req_valid, cq_index, cq_size,
    input  resp_valid, cq_offset
  );

  modport mgr (
    input  req_valid, cq_index, cq_size,
    output resp_valid, cq_offset
  );

endinterface

//--- egress_arbiter.sv
`timescale 1ns/100ps

module egress_arbiter (
  input  logic                       clk,
  input  logic                       i_rst_n,

  input  logic                       i_req_empty,
  output logic                       o_req_rd_en,
  input  logic [rdma_pkg::PKT_W-1:0] iv_req_data,

  input  logic                       i_resp_empty,
  output logic                       o_resp_rd_en,
  input  logic [rdma_pkg::PKT_W-1:0] iv_resp_data,

  input  logic                       i_arb_strict,

  input  logic                       i_outbound_pkt_prog_full,
  output logic                       o_outbound_pkt_wr_en,
  output logic [rdma_pkg::PKT_W-1:0] ov_outbound_pkt_data
);

  logic req_pend;
  logic resp_pend;
  logic pop;
  logic grant_resp;
  logic last_resp;

  assign req_pend  = !i_req_empty;
  assign resp_pend = !i_resp_empty;

  // No new pop while the link reports programmable-full
  assign pop = !i_outbound_pkt_prog_full && (req_pend || resp_pend);

  // Pick a stream when both hold words
  always_comb begin
    if (!req_pend) begin
      grant_resp = 1'b1;
    end else if (!resp_pend) begin
      grant_resp = 1'b0;
    end else if (i_arb_strict) begin
      grant_resp = 1'b1;
    end else begin
      // Round robin flips from the previous grant
      grant_resp = !last_resp;
    end
  end

  assign o_resp_rd_en = pop && grant_resp;
  assign o_req_rd_en  = pop && !grant_resp;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_outbound_pkt_wr_en <= 1'b0;
      last_resp            <= 1'b0;
    end else begin
      o_outbound_pkt_wr_en <= pop;
      if (pop) begin
        last_resp <= grant_resp;
      end
    end
  end

  // Output stage holds the popped word for one cycle
  always_ff @(posedge clk) begin
    if (pop) begin
      ov_outbound_pkt_data <= grant_resp ? iv_resp_data : iv_req_data;
    end
  end

endmodule

//--- engine_cfg_regs.sv
`timescale 1ns/100ps

module engine_cfg_regs (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  logic                             i_cfg_wr_en,
  input  logic [rdma_pkg::CFG_ADDR_W-1:0]  iv_cfg_addr,
  input  logic [rdma_pkg::CFG_W-1:0]       iv_cfg_wdata,
  output logic [rdma_pkg::CFG_W-1:0]       ov_cfg_rdata,
  output logic                             o_arb_strict,
  output logic [rdma_pkg::CQE_SHIFT_W-1:0] ov_cqe_shift
);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_arb_strict <= rdma_pkg::ARB_MODE_RESET;
      ov_cqe_shift <= rdma_pkg::CQE_SHIFT_RESET;
    end else if (i_cfg_wr_en) begin
      if (iv_cfg_addr == rdma_pkg::CFG_ARB_MODE_ADDR) begin
        o_arb_strict <= iv_cfg_wdata[0];
      end
      if (iv_cfg_addr == rdma_pkg::CFG_CQE_SHIFT_ADDR) begin
        ov_cqe_shift <= iv_cfg_wdata[rdma_pkg::CQE_SHIFT_W-1:0];
      end
    end
  end

  // Read mux returns zero for unmapped addresses
  always_comb begin
    ov_cfg_rdata = '0;
    case (iv_cfg_addr)
      rdma_pkg::CFG_ARB_MODE_ADDR: begin
        ov_cfg_rdata[0] = o_arb_strict;
      end
      rdma_pkg::CFG_CQE_SHIFT_ADDR: begin
        ov_cfg_rdata[rdma_pkg::CQE_SHIFT_W-1:0] = ov_cqe_shift;
      end
      default: begin
        ov_cfg_rdata = '0;
      end
    endcase
  end

endmodule

//--- flist.f
rdma_pkg.sv
cq_req_if.sv
engine_cfg_regs.sv
pkt_fifo.sv
egress_arbiter.sv
cq_offset_mgr.sv
rdma_engine.sv
tb_clk_gen.sv
tb_rdma_engine.sv

//--- pkt_fifo.sv
`timescale 1ns/100ps

module pkt_fifo #(
  parameter int WIDTH     = 256,
  parameter int DEPTH     = 16,
  parameter int PROG_FULL = 12
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_wr_en,
  input  logic [WIDTH-1:0] iv_din,
  input  logic             i_rd_en,
  output logic [WIDTH-1:0] ov_dout,
  output logic             o_empty,
  output logic             o_prog_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic [CW-1:0]    count_nxt;
  logic             do_wr;
  logic             do_rd;

  // A write into a full FIFO is dropped
  assign do_wr = i_wr_en && (count != CW'(DEPTH));
  assign do_rd = i_rd_en && !o_empty;

  always_comb begin
    count_nxt = count;
    if (do_wr && !do_rd) begin
      count_nxt = count + 1'b1;
    end else if (do_rd && !do_wr) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      o_prog_full <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count       <= count_nxt;
      o_prog_full <= (count_nxt >= PROG_FULL);
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= iv_din;
    end
  end

  // Head word shows ahead of the pop
  assign ov_dout = mem[rd_ptr];
  assign o_empty = (count == '0);

endmodule

//--- rdma_engine.sv
`timescale 1ns/100ps

module rdma_engine (
  input  logic                             clk,
  input  logic                             i_rst_n,

  // Packet FIFO writers
  input  logic                             i_req_pkt_wr_en,
  input  logic [rdma_pkg::PKT_W-1:0]       iv_req_pkt_data,
  output logic                             o_req_pkt_prog_full,
  input  logic                             i_resp_pkt_wr_en,
  input  logic [rdma_pkg::PKT_W-1:0]       iv_resp_pkt_data,
  output logic                             o_resp_pkt_prog_full,

  // Link layer
  input  logic                             i_outbound_pkt_prog_full,
  output logic                             o_outbound_pkt_wr_en,
  output logic [rdma_pkg::PKT_W-1:0]       ov_outbound_pkt_data,

  // Completion queue clients
  input  logic                             i_rtc_req_valid,
  input  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_rtc_cq_index,
  input  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_rtc_cq_size,
  output logic                             o_rtc_resp_valid,
  output logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_rtc_cq_offset,
  input  logic                             i_rrc_req_valid,
  input  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_rrc_cq_index,
  input  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_rrc_cq_size,
  output logic                             o_rrc_resp_valid,
  output logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_rrc_cq_offset,
  input  logic                             i_ee_req_valid,
  input  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_ee_cq_index,
  input  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_ee_cq_size,
  output logic                             o_ee_resp_valid,
  output logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_ee_cq_offset,

  // Configuration
  input  logic                             i_cfg_wr_en,
  input  logic [rdma_pkg::CFG_ADDR_W-1:0]  iv_cfg_addr,
  input  logic [rdma_pkg::CFG_W-1:0]       iv_cfg_wdata,
  output logic [rdma_pkg::CFG_W-1:0]       ov_cfg_rdata,

  output logic                             o_rdma_init_finish
);

  logic                             w_req_empty;
  logic                             w_req_rd_en;
  logic [rdma_pkg::PKT_W-1:0]       wv_req_dout;
  logic                             w_resp_empty;
  logic                             w_resp_rd_en;
  logic [rdma_pkg::PKT_W-1:0]       wv_resp_dout;
  logic                             w_arb_strict;
  logic [rdma_pkg::CQE_SHIFT_W-1:0] wv_cqe_shift;

  cq_req_if rtc_if ();
  cq_req_if rrc_if ();
  cq_req_if ee_if ();

  assign rtc_if.req_valid = i_rtc_req_valid;
  assign rtc_if.cq_index  = iv_rtc_cq_index;
  assign rtc_if.cq_size   = iv_rtc_cq_size;
  assign o_rtc_resp_valid = rtc_if.resp_valid;
  assign ov_rtc_cq_offset = rtc_if.cq_offset;

  assign rrc_if.req_valid = i_rrc_req_valid;
  assign rrc_if.cq_index  = iv_rrc_cq_index;
  assign rrc_if.cq_size   = iv_rrc_cq_size;
  assign o_rrc_resp_valid = rrc_if.resp_valid;
  assign ov_rrc_cq_offset = rrc_if.cq_offset;

  assign ee_if.req_valid  = i_ee_req_valid;
  assign ee_if.cq_index   = iv_ee_cq_index;
  assign ee_if.cq_size    = iv_ee_cq_size;
  assign o_ee_resp_valid  = ee_if.resp_valid;
  assign ov_ee_cq_offset  = ee_if.cq_offset;

  // Requester side packets
  pkt_fifo #(
    .WIDTH     (rdma_pkg::PKT_W),
    .DEPTH     (rdma_pkg::PKT_FIFO_DEPTH),
    .PROG_FULL (rdma_pkg::PKT_FIFO_PROG_FULL)
  ) req_trans_fifo (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (i_req_pkt_wr_en),
    .iv_din      (iv_req_pkt_data),
    .i_rd_en     (w_req_rd_en),
    .ov_dout     (wv_req_dout),
    .o_empty     (w_req_empty),
    .o_prog_full (o_req_pkt_prog_full)
  );

  // Responder side packets
  pkt_fifo #(
    .WIDTH     (rdma_pkg::PKT_W),
    .DEPTH     (rdma_pkg::PKT_FIFO_DEPTH),
    .PROG_FULL (rdma_pkg::PKT_FIFO_PROG_FULL)
  ) resp_trans_fifo (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (i_resp_pkt_wr_en),
    .iv_din      (iv_resp_pkt_data),
    .i_rd_en     (w_resp_rd_en),
    .ov_dout     (wv_resp_dout),
    .o_empty     (w_resp_empty),
    .o_prog_full (o_resp_pkt_prog_full)
  );

  egress_arbiter egress_arbiter_inst (
    .clk                      (clk),
    .i_rst_n                  (i_rst_n),
    .i_req_empty              (w_req_empty),
    .o_req_rd_en              (w_req_rd_en),
    .iv_req_data              (wv_req_dout),
    .i_resp_empty             (w_resp_empty),
    .o_resp_rd_en             (w_resp_rd_en),
    .iv_resp_data             (wv_resp_dout),
    .i_arb_strict             (w_arb_strict),
    .i_outbound_pkt_prog_full (i_outbound_pkt_prog_full),
    .o_outbound_pkt_wr_en     (o_outbound_pkt_wr_en),
    .ov_outbound_pkt_data     (ov_outbound_pkt_data)
  );

  cq_offset_mgr cqm_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .iv_cqe_shift  (wv_cqe_shift),
    .rtc           (rtc_if.mgr),
    .rrc           (rrc_if.mgr),
    .ee            (ee_if.mgr),
    .o_init_finish (o_rdma_init_finish)
  );

  engine_cfg_regs cfg_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cfg_wr_en  (i_cfg_wr_en),
    .iv_cfg_addr  (iv_cfg_addr),
    .iv_cfg_wdata (iv_cfg_wdata),
    .ov_cfg_rdata (ov_cfg_rdata),
    .o_arb_strict (w_arb_strict),
    .ov_cqe_shift (wv_cqe_shift)
  );

endmodule

//--- rdma_pkg.sv
package rdma_pkg;

  // Packet path
  localparam int PKT_W              = 256;
  localparam int PKT_FIFO_DEPTH     = 16;
  localparam int PKT_FIFO_PROG_FULL = 12;

  // Completion queue table
  localparam int CQ_INDEX_W  = 24;
  localparam int CQ_SIZE_W   = 32;
  localparam int CQ_OFFSET_W = 24;
  localparam int CQ_NUM      = 16;
  localparam int CQ_SEL_W    = 4;
  localparam int CQE_SHIFT_W = 4;

  // Client order is also service priority with RTC first
  localparam int CLIENT_NUM = 3;
  typedef enum logic [1:0] {RTC = 2'd0, RRC = 2'd1, EE = 2'd2} client_e;

  // Configuration space
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_W      = 32;
  localparam logic [CFG_ADDR_W-1:0]  CFG_ARB_MODE_ADDR  = 2'd0;
  localparam logic [CFG_ADDR_W-1:0]  CFG_CQE_SHIFT_ADDR = 2'd1;
  localparam logic [CQE_SHIFT_W-1:0] CQE_SHIFT_RESET    = 4'd5;
  localparam logic                   ARB_MODE_RESET     = 1'b0;

endpackage

//--- tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // Toggles every half period
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- tb_rdma_engine.sv
`timescale 1ns/100ps

module tb_rdma_engine;

  localparam int PKT_COUNT  = 60;
  localparam int REQ_COUNT  = 15;
  localparam int WAIT_LIMIT = 200;

  logic                             clk;
  logic                             i_rst_n;
  logic                             i_req_pkt_wr_en;
  logic [rdma_pkg::PKT_W-1:0]       iv_req_pkt_data;
  logic                             o_req_pkt_prog_full;
  logic                             i_resp_pkt_wr_en;
  logic [rdma_pkg::PKT_W-1:0]       iv_resp_pkt_data;
  logic                             o_resp_pkt_prog_full;
  logic                             i_outbound_pkt_prog_full;
  logic                             o_outbound_pkt_wr_en;
  logic [rdma_pkg::PKT_W-1:0]       ov_outbound_pkt_data;
  logic                             i_rtc_req_valid;
  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_rtc_cq_index;
  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_rtc_cq_size;
  logic                             o_rtc_resp_valid;
  logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_rtc_cq_offset;
  logic                             i_rrc_req_valid;
  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_rrc_cq_index;
  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_rrc_cq_size;
  logic                             o_rrc_resp_valid;
  logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_rrc_cq_offset;
  logic                             i_ee_req_valid;
  logic [rdma_pkg::CQ_INDEX_W-1:0]  iv_ee_cq_index;
  logic [rdma_pkg::CQ_SIZE_W-1:0]   iv_ee_cq_size;
  logic                             o_ee_resp_valid;
  logic [rdma_pkg::CQ_OFFSET_W-1:0] ov_ee_cq_offset;
  logic                             i_cfg_wr_en;
  logic [rdma_pkg::CFG_ADDR_W-1:0]  iv_cfg_addr;
  logic [rdma_pkg::CFG_W-1:0]       iv_cfg_wdata;
  logic [rdma_pkg::CFG_W-1:0]       ov_cfg_rdata;
  logic                             o_rdma_init_finish;

  integer                           seed = 32'hfb79_f596;
  logic [rdma_pkg::PKT_W-1:0]       req_q [$];
  logic [rdma_pkg::PKT_W-1:0]       resp_q [$];
  logic [rdma_pkg::PKT_W-1:0]       out_q [$];
  logic [rdma_pkg::CQ_OFFSET_W-1:0] model_ptr [rdma_pkg::CQ_NUM];
  int                               model_shift;

  tb_clk_gen #(.PERIOD_NS(20)) clk_gen_inst (.o_clk(clk));

  rdma_engine DUT (.*);

  // Captures outbound writes away from the driving edge
  always @(negedge clk) begin
    if (o_outbound_pkt_wr_en === 1'b1) begin
      out_q.push_back(ov_outbound_pkt_data);
    end
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_pkt(input string name, input logic [rdma_pkg::PKT_W-1:0] act,
                           input logic [rdma_pkg::PKT_W-1:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_offset(input string name, input logic [rdma_pkg::CQ_OFFSET_W-1:0] act,
                              input logic [rdma_pkg::CQ_OFFSET_W-1:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_cfg(input string name, input logic [rdma_pkg::CFG_W-1:0] act,
                           input logic [rdma_pkg::CFG_W-1:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
      stop_run();
    end
  endtask

  function automatic logic [rdma_pkg::PKT_W-1:0] rand_word();
    logic [rdma_pkg::PKT_W-1:0] w;
    for (int i = 0; i < rdma_pkg::PKT_W / 32; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  // Hands out the pointer and advances it by the entry size with a wrap at the queue end
  function automatic logic [rdma_pkg::CQ_OFFSET_W-1:0] model_take(
    input logic [rdma_pkg::CQ_INDEX_W-1:0] idx, input logic [rdma_pkg::CQ_SIZE_W-1:0] size);
    logic [rdma_pkg::CQ_SEL_W-1:0]    sel;
    logic [rdma_pkg::CQ_OFFSET_W-1:0] cur;
    logic [rdma_pkg::CQ_SIZE_W:0]     nxt;
    sel = idx[rdma_pkg::CQ_SEL_W-1:0];
    cur = model_ptr[sel];
    nxt = cur + (33'd1 << model_shift);
    model_ptr[sel] = (nxt >= size) ? '0 : nxt[rdma_pkg::CQ_OFFSET_W-1:0];
    return cur;
  endfunction

  function automatic logic resp_valid_of(input rdma_pkg::client_e c);
    case (c)
      rdma_pkg::RTC: return o_rtc_resp_valid;
      rdma_pkg::RRC: return o_rrc_resp_valid;
      default: return o_ee_resp_valid;
    endcase
  endfunction

  function automatic logic [rdma_pkg::CQ_OFFSET_W-1:0] resp_offset_of(input rdma_pkg::client_e c);
    case (c)
      rdma_pkg::RTC: return ov_rtc_cq_offset;
      rdma_pkg::RRC: return ov_rrc_cq_offset;
      default: return ov_ee_cq_offset;
    endcase
  endfunction

  function automatic string offset_name(input rdma_pkg::client_e c);
    case (c)
      rdma_pkg::RTC: return "ov_rtc_cq_offset";
      rdma_pkg::RRC: return "ov_rrc_cq_offset";
      default: return "ov_ee_cq_offset";
    endcase
  endfunction

  task automatic drive_req(input rdma_pkg::client_e c, input logic valid,
                           input logic [rdma_pkg::CQ_INDEX_W-1:0] idx,
                           input logic [rdma_pkg::CQ_SIZE_W-1:0] size);
    case (c)
      rdma_pkg::RTC: begin
        i_rtc_req_valid <= valid;
        iv_rtc_cq_index <= idx;
        iv_rtc_cq_size  <= size;
      end
      rdma_pkg::RRC: begin
        i_rrc_req_valid <= valid;
        iv_rrc_cq_index <= idx;
        iv_rrc_cq_size  <= size;
      end
      default: begin
        i_ee_req_valid <= valid;
        iv_ee_cq_index <= idx;
        iv_ee_cq_size  <= size;
      end
    endcase
  endtask

  task automatic cfg_write(input logic [rdma_pkg::CFG_ADDR_W-1:0] addr,
                           input logic [rdma_pkg::CFG_W-1:0] data);
    @(posedge clk);
    i_cfg_wr_en  <= 1'b1;
    iv_cfg_addr  <= addr;
    iv_cfg_wdata <= data;
    @(posedge clk);
    i_cfg_wr_en  <= 1'b0;
  endtask

  task automatic cfg_read_check(input logic [rdma_pkg::CFG_ADDR_W-1:0] addr,
                                input logic [rdma_pkg::CFG_W-1:0] exp);
    @(posedge clk);
    iv_cfg_addr <= addr;
    @(negedge clk);
    check_cfg("ov_cfg_rdata", ov_cfg_rdata, exp);
  endtask

  task automatic load_fifos(input int n);
    logic [rdma_pkg::PKT_W-1:0] w_req;
    logic [rdma_pkg::PKT_W-1:0] w_resp;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      w_req  = rand_word();
      w_resp = rand_word();
      i_req_pkt_wr_en  <= 1'b1;
      iv_req_pkt_data  <= w_req;
      i_resp_pkt_wr_en <= 1'b1;
      iv_resp_pkt_data <= w_resp;
      req_q.push_back(w_req);
      resp_q.push_back(w_resp);
    end
    @(posedge clk);
    i_req_pkt_wr_en  <= 1'b0;
    i_resp_pkt_wr_en <= 1'b0;
  endtask

  task automatic wait_for_writes(input int n);
    int cycles;
    cycles = 0;
    while (out_q.size() < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure("Outbound port stopped before all loaded words came out");
      end
    end
  endtask

  // Replays the arbitration rules over the loaded words
  task automatic verify_egress(input logic strict);
    int                         ri;
    int                         si;
    logic                       both;
    logic                       take_resp;
    logic                       last_resp;
    logic [rdma_pkg::PKT_W-1:0] exp;
    if (out_q.size() != req_q.size() + resp_q.size()) begin
      report_failure("Number of outbound words differs from the number loaded");
    end
    ri        = 0;
    si        = 0;
    last_resp = 1'b0;
    for (int k = 0; k < out_q.size(); k++) begin
      both = (ri < req_q.size()) && (si < resp_q.size());
      if (!both) begin
        take_resp = (si < resp_q.size());
      end else if (strict) begin
        take_resp = 1'b1;
      end else if (k == 0) begin
        take_resp = (out_q[0] === resp_q[0]);
      end else begin
        take_resp = !last_resp;
      end
      if (take_resp) begin
        exp = resp_q[si];
        si++;
      end else begin
        exp = req_q[ri];
        ri++;
      end
      check_pkt("ov_outbound_pkt_data", out_q[k], exp);
      last_resp = take_resp;
    end
  endtask

  task automatic cq_request(input rdma_pkg::client_e c,
                            input logic [rdma_pkg::CQ_INDEX_W-1:0] idx,
                            input logic [rdma_pkg::CQ_SIZE_W-1:0] size);
    logic [rdma_pkg::CQ_OFFSET_W-1:0] exp;
    int                               cycles;
    exp = model_take(idx, size);
    @(posedge clk);
    drive_req(c, 1'b1, idx, size);
    @(posedge clk);
    drive_req(c, 1'b0, idx, size);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure("No completion queue response arrived");
      end
    end while (resp_valid_of(c) !== 1'b1);
    check_offset(offset_name(c), resp_offset_of(c), exp);
  endtask

  task automatic test_init();
    int cycles;
    cycles = 0;
    while (o_rdma_init_finish !== 1'b1) begin
      @(negedge clk);
      cycles++;
      check_flag("o_outbound_pkt_wr_en", o_outbound_pkt_wr_en, 1'b0);
      check_flag("o_req_pkt_prog_full", o_req_pkt_prog_full, 1'b0);
      check_flag("o_resp_pkt_prog_full", o_resp_pkt_prog_full, 1'b0);
      check_flag("o_rtc_resp_valid", o_rtc_resp_valid, 1'b0);
      check_flag("o_rrc_resp_valid", o_rrc_resp_valid, 1'b0);
      check_flag("o_ee_resp_valid", o_ee_resp_valid, 1'b0);
      if (cycles > rdma_pkg::CQ_NUM + 4) begin
        report_failure("Init finish did not rise in time after reset");
      end
    end
    cfg_read_check(rdma_pkg::CFG_ARB_MODE_ADDR, 32'(rdma_pkg::ARB_MODE_RESET));
    cfg_read_check(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'(rdma_pkg::CQE_SHIFT_RESET));
  endtask

  task automatic test_cfg();
    cfg_write(rdma_pkg::CFG_ARB_MODE_ADDR, 32'hffff_fffe);
    cfg_read_check(rdma_pkg::CFG_ARB_MODE_ADDR, 32'h0);
    cfg_write(rdma_pkg::CFG_ARB_MODE_ADDR, 32'h8000_0001);
    cfg_read_check(rdma_pkg::CFG_ARB_MODE_ADDR, 32'h1);
    cfg_write(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'habcd_0007);
    cfg_read_check(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'h7);
    // Unmapped space holds nothing
    cfg_write(2'd2, 32'h1234_5678);
    cfg_read_check(2'd2, 32'h0);
    cfg_read_check(2'd3, 32'h0);
    cfg_read_check(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'h7);
    cfg_write(rdma_pkg::CFG_ARB_MODE_ADDR, 32'h0);
    cfg_write(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'h5);
    cfg_read_check(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'h5);
  endtask

  task automatic test_egress_order(input logic strict);
    cfg_write(rdma_pkg::CFG_ARB_MODE_ADDR, {31'd0, strict});
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b1;
    out_q.delete();
    req_q.delete();
    resp_q.delete();
    // One word below the threshold keeps both flags low
    load_fifos(rdma_pkg::PKT_FIFO_PROG_FULL - 1);
    repeat (2) @(negedge clk);
    check_flag("o_req_pkt_prog_full", o_req_pkt_prog_full, 1'b0);
    check_flag("o_resp_pkt_prog_full", o_resp_pkt_prog_full, 1'b0);
    load_fifos(1);
    repeat (2) @(negedge clk);
    check_flag("o_req_pkt_prog_full", o_req_pkt_prog_full, 1'b1);
    check_flag("o_resp_pkt_prog_full", o_resp_pkt_prog_full, 1'b1);
    if (out_q.size() != 0) begin
      report_failure("Outbound write happened while the link reported full");
    end
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b0;
    wait_for_writes(2 * rdma_pkg::PKT_FIFO_PROG_FULL);
    repeat (3) @(negedge clk);
    verify_egress(strict);
    check_flag("o_req_pkt_prog_full", o_req_pkt_prog_full, 1'b0);
    check_flag("o_resp_pkt_prog_full", o_resp_pkt_prog_full, 1'b0);
  endtask

  task automatic test_back_pressure();
    int base;
    cfg_write(rdma_pkg::CFG_ARB_MODE_ADDR, 32'h0);
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b1;
    out_q.delete();
    req_q.delete();
    resp_q.delete();
    load_fifos(6);
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b0;
    wait_for_writes(3);
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b1;
    base = out_q.size();
    repeat (6) @(negedge clk);
    if (out_q.size() > base + 1) begin
      report_failure("More than one outbound write followed the full flag");
    end
    @(posedge clk);
    i_outbound_pkt_prog_full <= 1'b0;
    wait_for_writes(12);
    repeat (3) @(negedge clk);
    verify_egress(1'b0);
  endtask

  task automatic test_cq_offsets();
    model_shift = 5;
    repeat (5) cq_request(rdma_pkg::RTC, 24'h00_0003, 32'd128);
    // Upper index bits fall outside the table select
    cq_request(rdma_pkg::RRC, 24'h10_0003, 32'd128);
    cq_request(rdma_pkg::EE, 24'h00_0007, 32'd256);
    cfg_write(rdma_pkg::CFG_CQE_SHIFT_ADDR, 32'h6);
    model_shift = 6;
    repeat (5) cq_request(rdma_pkg::EE, 24'h00_0007, 32'd256);
  endtask

  task automatic test_contention();
    logic [rdma_pkg::CQ_OFFSET_W-1:0] exp [rdma_pkg::CLIENT_NUM];
    logic [rdma_pkg::CLIENT_NUM-1:0]  got;
    rdma_pkg::client_e                c;
    for (int i = 0; i < rdma_pkg::CLIENT_NUM; i++) begin
      exp[i] = model_take(24'h00_0003, 32'd128);
    end
    @(posedge clk);
    drive_req(rdma_pkg::RTC, 1'b1, 24'h00_0003, 32'd128);
    drive_req(rdma_pkg::RRC, 1'b1, 24'h00_0003, 32'd128);
    drive_req(rdma_pkg::EE, 1'b1, 24'h00_0003, 32'd128);
    @(posedge clk);
    drive_req(rdma_pkg::RTC, 1'b0, 24'h00_0003, 32'd128);
    drive_req(rdma_pkg::RRC, 1'b0, 24'h00_0003, 32'd128);
    drive_req(rdma_pkg::EE, 1'b0, 24'h00_0003, 32'd128);
    got = '0;
    repeat (8) begin
      @(negedge clk);
      for (int i = 0; i < rdma_pkg::CLIENT_NUM; i++) begin
        c = rdma_pkg::client_e'(i);
        if (resp_valid_of(c) === 1'b1) begin
          if (got[i]) begin
            report_failure("A client received a second response to one request");
          end
          got[i] = 1'b1;
          check_offset(offset_name(c), resp_offset_of(c), exp[i]);
        end
      end
    end
    if (got != '1) begin
      report_failure("A client never received its completion queue response");
    end
  endtask

  // Limit scaled from the amount of traffic in the tests
  initial begin
    #((PKT_COUNT + REQ_COUNT + rdma_pkg::CQ_NUM) * 40 * 20 + 2000);
    report_failure("Watchdog expired before the tests completed");
  end

  initial begin
    i_rst_n                  = 1'b0;
    i_req_pkt_wr_en          = 1'b0;
    iv_req_pkt_data          = '0;
    i_resp_pkt_wr_en         = 1'b0;
    iv_resp_pkt_data         = '0;
    i_outbound_pkt_prog_full = 1'b0;
    i_rtc_req_valid          = 1'b0;
    iv_rtc_cq_index          = '0;
    iv_rtc_cq_size           = '0;
    i_rrc_req_valid          = 1'b0;
    iv_rrc_cq_index          = '0;
    iv_rrc_cq_size           = '0;
    i_ee_req_valid           = 1'b0;
    iv_ee_cq_index           = '0;
    iv_ee_cq_size            = '0;
    i_cfg_wr_en              = 1'b0;
    iv_cfg_addr              = '0;
    iv_cfg_wdata             = '0;
    for (int i = 0; i < rdma_pkg::CQ_NUM; i++) begin
      model_ptr[i] = '0;
    end
    repeat (4) @(posedge clk);
    i_rst_n <= 1'b1;
    test_init();
    test_cfg();
    test_egress_order(1'b1);
    test_egress_order(1'b0);
    test_back_pressure();
    test_cq_offsets();
    test_contention();
    repeat (2) @(posedge clk);
    $display("Test passed");
    $finish;
  end

endmodule
